//--- rtl/trace_pkg.sv
// XLEN is fixed at 64 and the 8-bit port index field limits the stream to 256 commit ports
package trace_pkg;

  // ----------------------------
  // widths
  // ----------------------------
  localparam int unsigned XLEN       = 64;
  localparam int unsigned INSN_W     = 32;
  // top bit of the cause marks an interrupt
  localparam int unsigned CAUSE_W    = XLEN;
  localparam int unsigned PORT_IDX_W = 8;

  // ----------------------------
  // enums
  // ----------------------------
  // riscv privilege encoding with 2'b10 reserved
  typedef enum logic [1:0] {
    priv_u = 2'b00,
    priv_s = 2'b01,
    priv_m = 2'b11
  } priv_lvl_e;

  // mode letter shown in the trace record
  typedef enum logic [1:0] {
    mode_u = 2'b00,
    mode_s = 2'b01,
    mode_m = 2'b10,
    mode_d = 2'b11
  } trace_mode_e;

  // ----------------------------
  // structs
  // ----------------------------
  typedef struct packed {
    logic               valid;
    logic [CAUSE_W-1:0] cause;
    logic [XLEN-1:0]    tval;
  } exception_t;

  // one entry as handed over by the commit stage
  typedef struct packed {
    logic [XLEN-1:0]   pc;
    logic [INSN_W-1:0] insn;
    exception_t        ex;
  } commit_instr_t;

  typedef struct packed {
    logic               valid;
    logic               exception;
    logic               interrupt;
    logic [XLEN-1:0]    iaddr;
    logic [INSN_W-1:0]  insn;
    trace_mode_e        mode;
    logic [CAUSE_W-1:0] cause;
    logic [XLEN-1:0]    tval;
  } trace_port_t;

  // entry of the merged pc stream
  typedef struct packed {
    logic [XLEN-1:0]       pc;
    logic [PORT_IDX_W-1:0] port;
  } pc_trace_t;

endpackage

//--- rtl/commit_classifier.sv
// Commit inputs are single-cycle strobes with no back-pressure; outputs lag the inputs by one edge
`timescale 1ns/10ps

module commit_classifier #(
  parameter int unsigned NrCommitPorts = 2
) (
  input  logic                                                clk_i,
  input  logic                                                rst_ni,
  input  trace_pkg::commit_instr_t [NrCommitPorts-1:0]        commit_instr_i,
  input  logic [NrCommitPorts-1:0]                            commit_ack_i,
  input  trace_pkg::priv_lvl_e                                priv_lvl_i,
  input  logic                                                debug_mode_i,
  output trace_pkg::trace_port_t [NrCommitPorts-1:0]          trace_o,
  output logic [NrCommitPorts-1:0]                            push_o,
  output logic [NrCommitPorts-1:0][trace_pkg::XLEN-1:0]       push_pc_o
);

  import trace_pkg::*;

  logic [NrCommitPorts-1:0] retire, excep, intr;
  trace_mode_e              cur_mode;

  // control state
  logic [NrCommitPorts-1:0] valid_q, excep_q, intr_q;

  // payload
  logic [NrCommitPorts-1:0][XLEN-1:0]    iaddr_q;
  logic [NrCommitPorts-1:0][INSN_W-1:0]  insn_q;
  logic [NrCommitPorts-1:0][CAUSE_W-1:0] cause_q;
  logic [NrCommitPorts-1:0][XLEN-1:0]    tval_q;
  trace_mode_e                           mode_q;

  // ----------------------------
  // classification
  // ----------------------------
  always_comb begin
    for (int unsigned p = 0; p < NrCommitPorts; p++) begin
      retire[p] = commit_ack_i[p] & ~commit_instr_i[p].ex.valid;
      // split on the interrupt bit of the cause
      excep[p]  = commit_ack_i[p] & commit_instr_i[p].ex.valid
                & ~commit_instr_i[p].ex.cause[CAUSE_W-1];
      intr[p]   = commit_ack_i[p] & commit_instr_i[p].ex.valid
                & commit_instr_i[p].ex.cause[CAUSE_W-1];
    end
  end

  // debug overrides the privilege level
  always_comb begin
    if (debug_mode_i) begin
      cur_mode = mode_d;
    end else begin
      case (priv_lvl_i)
        priv_u:  cur_mode = mode_u;
        priv_s:  cur_mode = mode_s;
        default: cur_mode = mode_m;
      endcase
    end
  end

  // ----------------------------
  // registers
  // ----------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
      excep_q <= '0;
      intr_q  <= '0;
    end else begin
      valid_q <= retire;
      excep_q <= excep;
      intr_q  <= intr;
    end
  end

  always_ff @(posedge clk_i) begin
    mode_q <= cur_mode;
    for (int unsigned p = 0; p < NrCommitPorts; p++) begin
      iaddr_q[p] <= commit_instr_i[p].pc;
      insn_q[p]  <= commit_instr_i[p].insn;
      cause_q[p] <= commit_instr_i[p].ex.cause;
      tval_q[p]  <= commit_instr_i[p].ex.tval;
    end
  end

  // ----------------------------
  // outputs
  // ----------------------------
  always_comb begin
    for (int unsigned p = 0; p < NrCommitPorts; p++) begin
      trace_o[p].valid     = valid_q[p];
      trace_o[p].exception = excep_q[p];
      trace_o[p].interrupt = intr_q[p];
      trace_o[p].iaddr     = iaddr_q[p];
      trace_o[p].insn      = insn_q[p];
      trace_o[p].mode      = mode_q;
      trace_o[p].cause     = cause_q[p];
      trace_o[p].tval      = tval_q[p];
    end
  end

  // the retire strobe doubles as the queue push
  assign push_o    = valid_q;
  assign push_pc_o = iaddr_q;

endmodule

//--- rtl/pc_queue.sv
// PcQueueDepth must be a power of two of at least 2; a push into a full queue is lost
`timescale 1ns/10ps

module pc_queue #(
  parameter int unsigned PcQueueDepth = 4
) (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       push_i,
  input  logic                       pop_i,
  input  logic [trace_pkg::XLEN-1:0] data_i,
  output logic [trace_pkg::XLEN-1:0] data_o,
  output logic                       not_empty_o,
  output logic                       overflow_o
);

  import trace_pkg::*;

  localparam int unsigned    AddrW     = $clog2(PcQueueDepth);
  localparam logic [AddrW:0] FullCount = (AddrW + 1)'(PcQueueDepth);

  logic [XLEN-1:0]  mem_q [PcQueueDepth];
  logic [AddrW-1:0] rd_ptr_q, wr_ptr_q;
  logic [AddrW:0]   count_q;
  logic             overflow_q;

  logic full, push_ok, pop_ok, drop;

  assign full    = (count_q == FullCount);
  assign pop_ok  = pop_i & not_empty_o;
  // a simultaneous pop frees the slot
  assign push_ok = push_i & (~full | pop_ok);
  assign drop    = push_i & ~push_ok;

  // ----------------------------
  // pointers and fill count
  // ----------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_ptr_q   <= '0;
      wr_ptr_q   <= '0;
      count_q    <= '0;
      overflow_q <= 1'b0;
    end else begin
      if (push_ok) begin
        wr_ptr_q <= wr_ptr_q + AddrW'(1);
      end
      if (pop_ok) begin
        rd_ptr_q <= rd_ptr_q + AddrW'(1);
      end
      case ({push_ok, pop_ok})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
      // sticky until reset
      if (drop) begin
        overflow_q <= 1'b1;
      end
    end
  end

  // storage
  always_ff @(posedge clk_i) begin
    if (push_ok) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  // head is read straight from the array
  assign data_o      = mem_q[rd_ptr_q];
  assign not_empty_o = (count_q != '0);
  assign overflow_o  = overflow_q;

endmodule

//--- rtl/pc_rr_arbiter.sv
// Works for 1 to 8 ports; pops at most one queue per cycle and the stream has no ready
`timescale 1ns/10ps

module pc_rr_arbiter #(
  parameter int unsigned NrCommitPorts = 2
) (
  input  logic                                          clk_i,
  input  logic                                          rst_ni,
  input  logic [NrCommitPorts-1:0]                      not_empty_i,
  input  logic [NrCommitPorts-1:0][trace_pkg::XLEN-1:0] head_pc_i,
  output logic [NrCommitPorts-1:0]                      pop_o,
  output logic                                          pc_valid_o,
  output trace_pkg::pc_trace_t                          pc_trace_o
);

  import trace_pkg::*;

  localparam int unsigned IdxW    = (NrCommitPorts > 1) ? $clog2(NrCommitPorts) : 1;
  localparam logic [IdxW-1:0] LastIdx = IdxW'(NrCommitPorts - 1);

  logic [IdxW-1:0] rr_ptr_q, gnt_idx, ptr_next;
  logic            gnt_found;
  logic            pc_valid_q;
  pc_trace_t       pc_trace_q;

  // ----------------------------
  // search from the pointer
  // ----------------------------
  always_comb begin
    int unsigned cand;
    gnt_found = 1'b0;
    gnt_idx   = '0;
    pop_o     = '0;
    for (int unsigned k = 0; k < NrCommitPorts; k++) begin
      cand = int'(rr_ptr_q) + k;
      // wrap without a modulo
      if (cand >= NrCommitPorts) begin
        cand = cand - NrCommitPorts;
      end
      if (!gnt_found && not_empty_i[cand]) begin
        gnt_found   = 1'b1;
        gnt_idx     = IdxW'(cand);
        pop_o[cand] = 1'b1;
      end
    end
  end

  // pointer goes one past the winner
  assign ptr_next = (gnt_idx == LastIdx) ? '0 : gnt_idx + 1'b1;

  // ----------------------------
  // registers
  // ----------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rr_ptr_q   <= '0;
      pc_valid_q <= 1'b0;
    end else begin
      pc_valid_q <= gnt_found;
      if (gnt_found) begin
        rr_ptr_q <= ptr_next;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (gnt_found) begin
      pc_trace_q.pc   <= head_pc_i[gnt_idx];
      pc_trace_q.port <= PORT_IDX_W'(gnt_idx);
    end
  end

  assign pc_valid_o = pc_valid_q;
  assign pc_trace_o = pc_trace_q;

endmodule

//--- rtl/commit_trace_top.sv
// NrCommitPorts 1 to 8, PcQueueDepth a power of two; overflow_o marks queues that lost PCs
`timescale 1ns/10ps

module commit_trace_top #(
  parameter int unsigned NrCommitPorts = 2,
  parameter int unsigned PcQueueDepth  = 4
) (
  input  logic                                         clk_i,
  input  logic                                         rst_ni,
  // commit side
  input  trace_pkg::commit_instr_t [NrCommitPorts-1:0] commit_instr_i,
  input  logic [NrCommitPorts-1:0]                     commit_ack_i,
  input  trace_pkg::priv_lvl_e                         priv_lvl_i,
  input  logic                                         debug_mode_i,
  // trace side
  output trace_pkg::trace_port_t [NrCommitPorts-1:0]   trace_o,
  output logic                                         pc_valid_o,
  output trace_pkg::pc_trace_t                         pc_trace_o,
  output logic [NrCommitPorts-1:0]                     overflow_o
);

  import trace_pkg::*;

  // ----------------------------
  // classifier to queues
  // ----------------------------
  logic [NrCommitPorts-1:0]           push;
  logic [NrCommitPorts-1:0][XLEN-1:0] push_pc;

  // queues to arbiter
  logic [NrCommitPorts-1:0]           not_empty;
  logic [NrCommitPorts-1:0][XLEN-1:0] head_pc;
  logic [NrCommitPorts-1:0]           pop;

  commit_classifier #(
    .NrCommitPorts ( NrCommitPorts )
  ) commit_classifier_i (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .commit_instr_i ( commit_instr_i ),
    .commit_ack_i   ( commit_ack_i   ),
    .priv_lvl_i     ( priv_lvl_i     ),
    .debug_mode_i   ( debug_mode_i   ),
    .trace_o        ( trace_o        ),
    .push_o         ( push           ),
    .push_pc_o      ( push_pc        )
  );

  // ----------------------------
  // one pc queue per port
  // ----------------------------
  for (genvar p = 0; p < NrCommitPorts; p++) begin : gen_pc_queue
    pc_queue #(
      .PcQueueDepth ( PcQueueDepth )
    ) pc_queue_i (
      .clk_i       ( clk_i         ),
      .rst_ni      ( rst_ni        ),
      .push_i      ( push[p]       ),
      .pop_i       ( pop[p]        ),
      .data_i      ( push_pc[p]    ),
      .data_o      ( head_pc[p]    ),
      .not_empty_o ( not_empty[p]  ),
      .overflow_o  ( overflow_o[p] )
    );
  end

  // single drain into the stream
  pc_rr_arbiter #(
    .NrCommitPorts ( NrCommitPorts )
  ) pc_rr_arbiter_i (
    .clk_i       ( clk_i      ),
    .rst_ni      ( rst_ni     ),
    .not_empty_i ( not_empty  ),
    .head_pc_i   ( head_pc    ),
    .pop_o       ( pop        ),
    .pc_valid_o  ( pc_valid_o ),
    .pc_trace_o  ( pc_trace_o )
  );

endmodule

//--- verification/tb_clk_gen.sv
// Free-running 4 ns clock; reset is held low for the first three rising edges only
`timescale 1ns/10ps

module tb_clk_gen #(
  parameter int unsigned ResetCycles = 3
) (
  output logic clk_o,
  output logic rst_no
);

  localparam real HalfPeriod = 2.0;

  initial begin
    clk_o = 1'b0;
    forever #(HalfPeriod) clk_o = ~clk_o;
  end

  // release just after an edge so the DUT sees a clean deassertion
  initial begin
    rst_no = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    #1 rst_no = 1'b1;
  end

endmodule

//--- verification/tb_commit_trace.sv
// Table rows are written for two commit ports; PCs are unique so dropped entries can be skipped
`timescale 1ns/10ps

module tb_commit_trace;

  import trace_pkg::*;

  localparam int unsigned NrPorts      = 2;
  localparam int unsigned PcQueueDepth = 4;

  typedef trace_port_t [NrPorts-1:0] trace_vec_t;

  typedef struct packed {
    logic [NrPorts-1:0]          ack;
    commit_instr_t [NrPorts-1:0] instr;
    priv_lvl_e                   priv;
    logic                        debug;
  } stim_row_t;

  // one table entry with stimulus and the trace expected a cycle later
  typedef struct packed {
    stim_row_t  stim;
    trace_vec_t exp;
    logic       rr;
    logic       burst;
  } table_row_t;

  logic                        clk;
  logic                        rst_n;
  commit_instr_t [NrPorts-1:0] commit_instr;
  logic [NrPorts-1:0]          commit_ack;
  priv_lvl_e                   priv_lvl;
  logic                        debug_mode;
  trace_vec_t                  trace_o;
  logic                        pc_valid_o;
  pc_trace_t                   pc_trace_o;
  logic [NrPorts-1:0]          overflow_o;

  table_row_t      tbl[$];
  logic [XLEN-1:0] model_q [NrPorts][$];
  logic [31:0]     lcg_state;
  int unsigned     timeout_limit = 0;
  int unsigned     cycle_cnt = 0;
  int unsigned     last_port = 0;
  bit              have_last = 1'b0;
  bit              rr_active = 1'b0;
  bit              burst_started = 1'b0;
  logic [NrPorts-1:0] ovf_seen = '0;

  tb_clk_gen clk_gen_i (
    .clk_o  ( clk   ),
    .rst_no ( rst_n )
  );

  commit_trace_top #(
    .NrCommitPorts ( NrPorts      ),
    .PcQueueDepth  ( PcQueueDepth )
  ) commit_trace_top_i (
    .clk_i          ( clk          ),
    .rst_ni         ( rst_n        ),
    .commit_instr_i ( commit_instr ),
    .commit_ack_i   ( commit_ack   ),
    .priv_lvl_i     ( priv_lvl     ),
    .debug_mode_i   ( debug_mode   ),
    .trace_o        ( trace_o      ),
    .pc_valid_o     ( pc_valid_o   ),
    .pc_trace_o     ( pc_trace_o   ),
    .overflow_o     ( overflow_o   )
  );

  // ------------------------------
  // failure handling and compares
  // ------------------------------
  task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("Testbench failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_trace(input string name, input trace_port_t exp, input trace_port_t act);
    logic [2:0] exp_flags;
    logic [2:0] act_flags;
    exp_flags = {exp.valid, exp.exception, exp.interrupt};
    act_flags = {act.valid, act.exception, act.interrupt};
    // payload only matters when the record carries an event
    if (exp_flags == 3'b000) begin
      if (act_flags !== exp_flags) begin
        stop_on_error($sformatf("[ERROR] %0t %s.flags expected %b actual %b",
                                $time, name, exp_flags, act_flags));
      end
    end else if (act !== exp) begin
      stop_on_error($sformatf("[ERROR] %0t %s expected %h actual %h", $time, name, exp, act));
    end
  endtask

  task automatic check_pc(input string name, input pc_trace_t exp, input pc_trace_t act);
    if (act !== exp) begin
      stop_on_error($sformatf("[ERROR] %0t %s expected %h actual %h", $time, name, exp, act));
    end
  endtask

  task automatic check_overflow(input string name, input logic [NrPorts-1:0] exp,
                                input logic [NrPorts-1:0] act);
    if (act !== exp) begin
      stop_on_error($sformatf("[ERROR] %0t %s expected %b actual %b", $time, name, exp, act));
    end
  endtask

  // ------------------------------
  // reference model
  // ------------------------------
  function automatic logic [31:0] lcg_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic trace_mode_e mode_letter(input priv_lvl_e priv, input logic dbg);
    if (dbg) begin
      return mode_d;
    end else if (priv == priv_u) begin
      return mode_u;
    end else if (priv == priv_s) begin
      return mode_s;
    end else begin
      return mode_m;
    end
  endfunction

  function automatic trace_vec_t expected_trace(input stim_row_t s);
    trace_vec_t t;
    logic       is_irq;
    for (int p = 0; p < NrPorts; p++) begin
      is_irq           = s.instr[p].ex.cause[CAUSE_W-1];
      t[p].valid       = s.ack[p] & ~s.instr[p].ex.valid;
      t[p].exception   = s.ack[p] & s.instr[p].ex.valid & ~is_irq;
      t[p].interrupt   = s.ack[p] & s.instr[p].ex.valid & is_irq;
      t[p].iaddr       = s.instr[p].pc;
      t[p].insn        = s.instr[p].insn;
      t[p].mode        = mode_letter(s.priv, s.debug);
      t[p].cause       = s.instr[p].ex.cause;
      t[p].tval        = s.instr[p].ex.tval;
    end
    return t;
  endfunction

  // ------------------------------
  // stimulus table
  // ------------------------------
  task automatic add_row(input logic [NrPorts-1:0] ack, input logic [NrPorts-1:0] exc,
                         input logic [NrPorts-1:0] irq, input priv_lvl_e priv,
                         input logic dbg, input logic rr, input logic burst);
    table_row_t  row;
    logic [31:0] rnd;
    row            = '0;
    row.stim.ack   = ack;
    row.stim.priv  = priv;
    row.stim.debug = dbg;
    row.rr         = rr;
    row.burst      = burst;
    for (int p = 0; p < NrPorts; p++) begin
      rnd = lcg_rand();
      // row and port in the low half keep every pc unique
      row.stim.instr[p].pc       = {rnd, 16'(tbl.size()), 8'(p), 8'h00};
      row.stim.instr[p].insn     = lcg_rand();
      row.stim.instr[p].ex.valid = exc[p];
      row.stim.instr[p].ex.cause = {irq[p], 59'd0, rnd[3:0]};
      row.stim.instr[p].ex.tval  = {32'd0, lcg_rand()};
    end
    row.exp = expected_trace(row.stim);
    tbl.push_back(row);
  endtask

  task automatic build_table();
    logic [31:0] rnd;
    priv_lvl_e   priv;
    // sparse commits, events and mode letters
    add_row(2'b11, 2'b00, 2'b00, priv_m, 1'b0, 1'b0, 1'b0);
    add_row(2'b00, 2'b11, 2'b10, priv_s, 1'b0, 1'b0, 1'b0);
    add_row(2'b11, 2'b01, 2'b00, priv_s, 1'b0, 1'b0, 1'b0);
    add_row(2'b00, 2'b00, 2'b00, priv_u, 1'b0, 1'b0, 1'b0);
    add_row(2'b11, 2'b10, 2'b10, priv_u, 1'b0, 1'b0, 1'b0);
    add_row(2'b01, 2'b00, 2'b00, priv_m, 1'b1, 1'b0, 1'b0);
    add_row(2'b10, 2'b00, 2'b00, priv_s, 1'b1, 1'b0, 1'b0);
    add_row(2'b11, 2'b11, 2'b01, priv_m, 1'b0, 1'b0, 1'b0);
    add_row(2'b10, 2'b00, 2'b00, priv_u, 1'b0, 1'b0, 1'b0);
    repeat (6) add_row(2'b00, 2'b00, 2'b00, priv_m, 1'b0, 1'b0, 1'b0);
    // fill both queues and let them drain
    repeat (3) add_row(2'b11, 2'b00, 2'b00, priv_m, 1'b0, 1'b1, 1'b0);
    repeat (8) add_row(2'b00, 2'b00, 2'b00, priv_m, 1'b0, 1'b1, 1'b0);
    // ------------------------------
    // burst with every port on every cycle
    // ------------------------------
    for (int i = 0; i < 4 * PcQueueDepth; i++) begin
      rnd = lcg_rand();
      case (rnd % 3)
        0:       priv = priv_u;
        1:       priv = priv_s;
        default: priv = priv_m;
      endcase
      add_row('1, '0, '0, priv, rnd[7], 1'b0, 1'b1);
    end
  endtask

  task automatic drive_row(input stim_row_t s);
    commit_instr = s.instr;
    commit_ack   = s.ack;
    priv_lvl     = s.priv;
    debug_mode   = s.debug;
    for (int p = 0; p < NrPorts; p++) begin
      if (s.ack[p] && !s.instr[p].ex.valid) begin
        model_q[p].push_back(s.instr[p].pc);
      end
    end
  endtask

  // ------------------------------
  // output monitoring
  // ------------------------------
  task automatic match_stream_entry();
    pc_trace_t   act;
    pc_trace_t   exp;
    int unsigned p;
    bit          others_pending;
    act = pc_trace_o;
    // every table pc carries the number of the port it was driven on
    p   = int'(act.pc[15:8]);
    if (p >= NrPorts) begin
      stop_on_error($sformatf("stream entry carries PC %h, which no port retired", act.pc));
    end else if (model_q[p].size() == 0) begin
      stop_on_error($sformatf("stream entry for port %0d with no retired PC pending", p));
    end else begin
      others_pending = 1'b0;
      for (int unsigned q = 0; q < NrPorts; q++) begin
        if (q != p && model_q[q].size() != 0) begin
          others_pending = 1'b1;
        end
      end
      if (rr_active && have_last && last_port == p && others_pending) begin
        stop_on_error($sformatf("round-robin served port %0d twice while another queue waited",
                                p));
      end
      // dropped pcs never show up once that queue has overflowed
      while (overflow_o[p] && model_q[p].size() > 1 && model_q[p][0] != act.pc) begin
        void'(model_q[p].pop_front());
      end
      exp.pc   = model_q[p].pop_front();
      exp.port = PORT_IDX_W'(p);
      check_pc("pc_trace_o", exp, act);
      last_port = p;
      have_last = 1'b1;
    end
  endtask

  task automatic sample_outputs(input trace_vec_t exp);
    for (int p = 0; p < NrPorts; p++) begin
      check_trace($sformatf("trace_o[%0d]", p), exp[p], trace_o[p]);
    end
    if (!burst_started) begin
      check_overflow("overflow_o", '0, overflow_o);
    end else if ((overflow_o & ovf_seen) != ovf_seen) begin
      stop_on_error("an overflow flag cleared without a reset");
    end
    ovf_seen = ovf_seen | overflow_o;
    if (pc_valid_o) begin
      match_stream_entry();
    end
  endtask

  always @(posedge clk) begin
    if (rst_n) begin
      cycle_cnt++;
      if (cycle_cnt > timeout_limit) begin
        stop_on_error($sformatf("timeout, the run did not end within %0d cycles", timeout_limit));
      end
    end
  end

  initial begin
    trace_vec_t  exp_q;
    int unsigned quiet;
    bit          leftover;
    commit_instr = '0;
    commit_ack   = '0;
    priv_lvl     = priv_m;
    debug_mode   = 1'b0;
    lcg_state    = 32'hca71_d765;
    build_table();
    timeout_limit = tbl.size() + 8 * PcQueueDepth * NrPorts;
    exp_q = '0;
    @(posedge rst_n);
    for (int r = 0; r < tbl.size(); r++) begin
      @(posedge clk);
      #1;
      sample_outputs(exp_q);
      drive_row(tbl[r].stim);
      rr_active = tbl[r].rr;
      if (!rr_active) begin
        have_last = 1'b0;
      end
      if (tbl[r].burst) begin
        burst_started = 1'b1;
      end
      exp_q = tbl[r].exp;
    end
    // drain until the stream stays quiet
    quiet = 0;
    while (quiet < 4) begin
      @(posedge clk);
      #1;
      sample_outputs(exp_q);
      commit_ack = '0;
      exp_q      = '0;
      if (pc_valid_o) begin
        quiet = 0;
      end else begin
        quiet++;
      end
    end
    leftover = 1'b0;
    for (int p = 0; p < NrPorts; p++) begin
      // a full queue is still popped at least once every NrPorts cycles
      if (model_q[p].size() > (overflow_o[p] ? NrPorts - 1 : 0)) begin
        leftover = 1'b1;
      end
    end
    if (overflow_o == '0) begin
      stop_on_error("the commit burst did not set any overflow flag");
    end else if (leftover) begin
      stop_on_error("the PC stream ended with retired PCs still missing");
    end else begin
      $display("Testbench passed");
      $finish;
    end
  end

endmodule

//--- compile.f
rtl/trace_pkg.sv
rtl/commit_classifier.sv
rtl/pc_queue.sv
rtl/pc_rr_arbiter.sv
rtl/commit_trace_top.sv
verification/tb_clk_gen.sv
verification/tb_commit_trace.sv

//--- Makefile
# Verilator flow for the commit trace unit

VERILATOR ?= verilator
TOP       ?= tb_commit_trace
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
EXTRA     ?=

SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) $(EXTRA) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the binary exits non-zero when the testbench stops with $fatal
run: compile
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)
